/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_riscv_core

output=$(./obj_dir/Vtb_riscv_core)
echo "$output"

if grep -qx "test passed" <<< "$output"; then
    exit 0
fi
exit 1

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    input  cpu_pkg::alu_op_e op,
    input  logic             br_unsigned,
    output logic [31:0]      result,
    output logic             br_eq,
    output logic             br_lt
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:  result = a + b;
            cpu_pkg::ALU_SUB:  result = a - b;
            cpu_pkg::ALU_AND:  result = a & b;
            cpu_pkg::ALU_OR:   result = a | b;
            cpu_pkg::ALU_XOR:  result = a ^ b;
            cpu_pkg::ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            cpu_pkg::ALU_SLTU: result = {31'd0, a < b};
            cpu_pkg::ALU_SLL:  result = a << shamt;
            cpu_pkg::ALU_SRL:  result = a >> shamt;
            cpu_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            default:           result = b;    // PASS_B for lui
        endcase
    end

    // Branch compare on the same operands
    assign br_eq = a == b;
    assign br_lt = br_unsigned ? (a < b) : ($signed(a) < $signed(b));

endmodule

/* source/controller.sv */
`timescale 1ns/1ps

module controller (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           inst,
    input  logic                  br_eq,
    input  logic                  br_lt,
    input  logic                  stall,
    output cpu_pkg::pc_sel_e      pc_sel,
    output logic                  inst_nop,
    output logic                  reg_we,
    output logic                  a_sel,
    output logic                  b_sel,
    output logic                  br_unsigned,
    output logic                  mem_we,
    output cpu_pkg::imm_kind_e    imm_kind,
    output cpu_pkg::alu_op_e      alu_op,
    output cpu_pkg::mem_kind_e    mem_kind,
    output cpu_pkg::wb_sel_e      wb_sel,
    output logic                  fwd_d1,
    output logic                  fwd_d2,
    output logic                  fwd_e1,
    output logic                  fwd_e2
);
    logic [2:0] funct3;
    logic       d_reg_we, d_mem_we, d_branch, d_jump, d_a_sel, d_b_sel;
    cpu_pkg::alu_op_e   d_alu_op, ex_alu_op;
    cpu_pkg::mem_kind_e d_mem_kind, ex_mem_kind;
    cpu_pkg::wb_sel_e   d_wb_sel, ex_wb_sel, wb_wb_sel;

    // Execute and writeback stage state
    logic       ex_reg_we, ex_mem_we, ex_branch, ex_jump, ex_a_sel, ex_b_sel;
    logic [2:0] ex_funct3;
    logic [4:0] ex_rs1, ex_rs2, ex_rd, wb_rd;
    logic       wb_reg_we;
    logic       cond, taken;

    // funct3 to ALU operation; alt picks SUB / SRA
    function automatic cpu_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  arith_op = alt ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            3'b001:  arith_op = cpu_pkg::ALU_SLL;
            3'b010:  arith_op = cpu_pkg::ALU_SLT;
            3'b011:  arith_op = cpu_pkg::ALU_SLTU;
            3'b100:  arith_op = cpu_pkg::ALU_XOR;
            3'b101:  arith_op = alt ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            3'b110:  arith_op = cpu_pkg::ALU_OR;
            default: arith_op = cpu_pkg::ALU_AND;
        endcase
    endfunction

    assign funct3 = inst[14:12];

    always_comb begin
        d_reg_we   = 1'b0;
        d_mem_we   = 1'b0;
        d_branch   = 1'b0;
        d_jump     = 1'b0;
        d_a_sel    = 1'b0;             // rs1
        d_b_sel    = 1'b1;             // Immediate
        d_alu_op   = cpu_pkg::ALU_ADD;
        d_mem_kind = cpu_pkg::MEM_WORD;
        d_wb_sel   = cpu_pkg::WB_ALU;
        imm_kind   = cpu_pkg::IMM_I;
        case (cpu_pkg::opcode_e'(inst[6:0]))
            cpu_pkg::OPC_OP: begin
                d_reg_we = 1'b1;
                d_b_sel  = 1'b0;
                d_alu_op = arith_op(funct3, inst[30]);
            end
            cpu_pkg::OPC_OP_IMM: begin
                d_reg_we = 1'b1;
                d_alu_op = arith_op(funct3, inst[30] && funct3 == 3'b101);
            end
            cpu_pkg::OPC_LOAD: begin
                d_reg_we = 1'b1;
                d_wb_sel = cpu_pkg::WB_LOAD;
                if (funct3 == 3'b000)
                    d_mem_kind = cpu_pkg::MEM_BYTE;
                else if (funct3 == 3'b100)
                    d_mem_kind = cpu_pkg::MEM_BYTE_U;
            end
            cpu_pkg::OPC_STORE: begin
                d_mem_we = 1'b1;
                imm_kind = cpu_pkg::IMM_S;
                if (funct3 == 3'b000)
                    d_mem_kind = cpu_pkg::MEM_BYTE;
            end
            cpu_pkg::OPC_BRANCH: begin
                d_branch = 1'b1;
                d_b_sel  = 1'b0;      // ALU compares rs1 against rs2
                imm_kind = cpu_pkg::IMM_B;
            end
            cpu_pkg::OPC_JAL: begin
                d_reg_we = 1'b1;
                d_jump   = 1'b1;
                d_a_sel  = 1'b1;
                d_wb_sel = cpu_pkg::WB_LINK;
                imm_kind = cpu_pkg::IMM_J;
            end
            cpu_pkg::OPC_JALR: begin
                d_reg_we = 1'b1;
                d_jump   = 1'b1;
                d_wb_sel = cpu_pkg::WB_LINK;
            end
            cpu_pkg::OPC_LUI: begin
                d_reg_we = 1'b1;
                d_alu_op = cpu_pkg::ALU_PASS_B;
                imm_kind = cpu_pkg::IMM_U;
            end
            cpu_pkg::OPC_AUIPC: begin
                d_reg_we = 1'b1;
                d_a_sel  = 1'b1;
                imm_kind = cpu_pkg::IMM_U;
            end
            default: ;                 // Unknown opcodes behave as a NOP
        endcase
        if (inst[11:7] == 5'd0)
            d_reg_we = 1'b0;           // x0 never gets a result
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_reg_we   <= 1'b0;
            ex_mem_we   <= 1'b0;
            ex_branch   <= 1'b0;
            ex_jump     <= 1'b0;
            ex_a_sel    <= 1'b0;
            ex_b_sel    <= 1'b0;
            ex_alu_op   <= cpu_pkg::ALU_ADD;
            ex_mem_kind <= cpu_pkg::MEM_WORD;
            ex_wb_sel   <= cpu_pkg::WB_ALU;
            ex_funct3   <= 3'd0;
            ex_rs1      <= 5'd0;
            ex_rs2      <= 5'd0;
            ex_rd       <= 5'd0;
            wb_reg_we   <= 1'b0;
            wb_wb_sel   <= cpu_pkg::WB_ALU;
            wb_rd       <= 5'd0;
        end else if (!stall) begin
            ex_reg_we   <= d_reg_we;
            ex_mem_we   <= d_mem_we;
            ex_branch   <= d_branch;
            ex_jump     <= d_jump;
            ex_a_sel    <= d_a_sel;
            ex_b_sel    <= d_b_sel;
            ex_alu_op   <= d_alu_op;
            ex_mem_kind <= d_mem_kind;
            ex_wb_sel   <= d_wb_sel;
            ex_funct3   <= funct3;
            ex_rs1      <= inst[19:15];
            ex_rs2      <= inst[24:20];
            ex_rd       <= inst[11:7];
            wb_reg_we   <= ex_reg_we;
            wb_wb_sel   <= ex_wb_sel;
            wb_rd       <= ex_rd;
        end
    end

    // beq/bne use eq, the rest use lt; funct3[0] inverts
    assign cond  = (ex_funct3[2] ? br_lt : br_eq) ^ ex_funct3[0];
    assign taken = ex_jump || (ex_branch && cond);

    always_comb begin
        if (stall)
            pc_sel = cpu_pkg::PC_HOLD;
        else if (taken)
            pc_sel = cpu_pkg::PC_TARGET;
        else
            pc_sel = cpu_pkg::PC_PLUS4;
    end

    assign inst_nop    = taken;        // Squash the wrong-path instruction in decode
    assign a_sel       = ex_a_sel;
    assign b_sel       = ex_b_sel;
    assign alu_op      = ex_alu_op;
    assign br_unsigned = ex_funct3[1];
    assign mem_we      = ex_mem_we;
    assign mem_kind    = ex_mem_kind;
    assign wb_sel      = wb_wb_sel;
    assign reg_we      = wb_reg_we && !stall;

    // Writeback result bypasses the register file into decode and execute
    assign fwd_d1 = wb_reg_we && wb_rd == inst[19:15];
    assign fwd_d2 = wb_reg_we && wb_rd == inst[24:20];
    assign fwd_e1 = wb_reg_we && wb_rd == ex_rs1;
    assign fwd_e2 = wb_reg_we && wb_rd == ex_rs2;

endmodule

/* source/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath width
`define XLEN 32

// Memory depths in 32-bit words
`define IMEM_WORDS 256
`define DMEM_WORDS 256

`define RESET_PC 32'h0000_0000

// Address map
`define OUT_ADDR 32'h8000_0000
`define DMEM_REGION 4'b0001

`endif

/* source/cpu_pkg.sv */
package cpu_pkg;

    // RV32 major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_kind_e;

    typedef enum logic [1:0] {PC_PLUS4, PC_TARGET, PC_HOLD} pc_sel_e;

    // Writeback source
    typedef enum logic [1:0] {WB_LOAD, WB_ALU, WB_LINK} wb_sel_e;

    // Access size and sign for loads and stores
    typedef enum logic [1:0] {MEM_WORD, MEM_BYTE, MEM_BYTE_U} mem_kind_e;

endpackage

/* source/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen (
    input  logic [31:7]        inst,
    input  cpu_pkg::imm_kind_e kind,
    output logic [31:0]        imm
);
    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (kind)
            cpu_pkg::IMM_I: imm = {{20{sign}}, inst[31:20]};
            cpu_pkg::IMM_S: imm = {{20{sign}}, inst[31:25], inst[11:7]};
            cpu_pkg::IMM_B: begin
                imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            cpu_pkg::IMM_U: imm = {inst[31:12], 12'd0};
            cpu_pkg::IMM_J: begin
                imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default:        imm = 32'd0;
        endcase
    end

endmodule

/* source/mem_unit.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module mem_unit (
    input  logic                            clk,
    input  logic                            prog_we,
    input  logic [$clog2(`IMEM_WORDS)-1:0]  prog_addr,
    input  logic [31:0]                     prog_data,
    input  logic [31:0]                     fetch_addr,
    output logic [31:0]                     inst,
    input  logic [31:0]                     addr,
    input  logic [31:0]                     wdata,
    input  logic                            we,
    input  cpu_pkg::mem_kind_e              kind,
    output logic [31:0]                     rdata,
    output logic                            out_write
);
    localparam int IW = $clog2(`IMEM_WORDS);
    localparam int DW = $clog2(`DMEM_WORDS);

    logic [31:0] imem [`IMEM_WORDS];
    logic [31:0] dmem [`DMEM_WORDS];
    logic        dmem_sel;
    logic [3:0]  lane_we;
    logic [31:0] lane_data;
    logic [31:0] read_word;
    logic [1:0]  read_off;
    logic [7:0]  read_byte;
    cpu_pkg::mem_kind_e read_kind;

    // Instruction fetch reads on the next-PC value
    always_ff @(posedge clk) begin
        if (prog_we)
            imem[prog_addr] <= prog_data;
        inst <= imem[fetch_addr[IW+1:2]];
    end

    assign dmem_sel  = addr[31:28] == `DMEM_REGION;
    assign out_write = we && addr == `OUT_ADDR;

    // Byte stores go to the lane picked by addr[1:0]
    assign lane_we   = (kind == cpu_pkg::MEM_WORD) ? 4'b1111 : (4'b0001 << addr[1:0]);
    assign lane_data = (kind == cpu_pkg::MEM_WORD) ? wdata : ({4{wdata[7:0]}});

    always_ff @(posedge clk) begin
        if (dmem_sel) begin                  // Read side holds outside the data region
            read_word <= dmem[addr[DW+1:2]];
            read_off  <= addr[1:0];
            read_kind <= kind;
            for (int i = 0; i < 4; i++) begin
                if (we && lane_we[i])
                    dmem[addr[DW+1:2]][8*i +: 8] <= lane_data[8*i +: 8];
            end
        end
    end

    assign read_byte = read_word[8*read_off +: 8];

    always_comb begin
        case (read_kind)
            cpu_pkg::MEM_BYTE:   rdata = {{24{read_byte[7]}}, read_byte};
            cpu_pkg::MEM_BYTE_U: rdata = {24'd0, read_byte};
            default:             rdata = read_word;
        endcase
    end

endmodule

/* source/out_port.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module out_port (
    input  logic              clk,
    input  logic              rst,
    input  logic              write,
    input  logic [`XLEN-1:0]  wdata,
    output logic              out_req,
    output logic [`XLEN-1:0]  out_data,
    input  logic              out_ack,
    output logic              stall
);
    typedef enum logic {IDLE, BUSY} state_e;

    state_e state;
    logic   accept;

    // Port is free only once the previous ack has dropped
    assign stall  = write && (state == BUSY || out_ack);
    assign accept = write && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (accept) state <= BUSY;
                BUSY:    if (out_ack) state <= IDLE;     // Req drops the cycle after ack
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            out_data <= wdata;       // Stable for the whole req phase
    end

    assign out_req = state == BUSY;

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module reg_file (
    input  logic              clk,
    input  logic              we,
    input  logic [4:0]        ra1,
    input  logic [4:0]        ra2,
    input  logic [4:0]        wa,
    input  logic [`XLEN-1:0]  wd,
    output logic [`XLEN-1:0]  rd1,
    output logic [`XLEN-1:0]  rd2
);
    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0)
            regs[wa] <= wd;
    end

    // x0 is hardwired to zero
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

/* source/riscv_core.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module riscv_core (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            prog_we,
    input  logic [$clog2(`IMEM_WORDS)-1:0]  prog_addr,
    input  logic [31:0]                     prog_data,
    output logic                            out_req,
    output logic [`XLEN-1:0]                out_data,
    input  logic                            out_ack
);
    localparam logic [31:0] NOP = 32'h0000_0013;    // addi x0, x0, 0

    cpu_pkg::pc_sel_e   pc_sel;
    cpu_pkg::imm_kind_e imm_kind;
    cpu_pkg::alu_op_e   alu_op;
    cpu_pkg::mem_kind_e mem_kind;
    cpu_pkg::wb_sel_e   wb_sel;
    logic inst_nop, reg_we, a_sel, b_sel, br_unsigned, mem_we;
    logic fwd_d1, fwd_d2, fwd_e1, fwd_e2;
    logic br_eq, br_lt, stall, out_write;

    logic [31:0] pc, pc_plus4, next_pc, target;
    logic [31:0] fetch_inst, inst, imm;
    logic [31:0] rd1, rd2, dec_op1, dec_op2;
    logic [31:0] ex_pc, ex_pc4, ex_rs1, ex_rs2, ex_imm;
    logic [31:0] ex_op1, ex_op2, alu_a, alu_b, alu_result;
    logic [31:0] wb_alu, wb_pc4, load_data, wd;
    logic [4:0]  ex_rd, wb_rd;

    // Fetch and decode
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (pc_sel)
            cpu_pkg::PC_TARGET: next_pc = target;
            cpu_pkg::PC_HOLD:   next_pc = pc;
            default:            next_pc = pc_plus4;
        endcase
        if (rst)
            next_pc = `RESET_PC;     // First fetch lines up with the reset PC
    end

    always_ff @(posedge clk) begin
        if (rst)
            pc <= `RESET_PC;
        else
            pc <= next_pc;
    end

    assign inst    = inst_nop ? NOP : fetch_inst;
    assign dec_op1 = fwd_d1 ? wd : rd1;
    assign dec_op2 = fwd_d2 ? wd : rd2;

    // Decode to execute
    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_pc  <= pc;
            ex_pc4 <= pc_plus4;
            ex_rs1 <= dec_op1;
            ex_rs2 <= dec_op2;
            ex_imm <= imm;
            ex_rd  <= inst[11:7];
        end
    end

    // Execute
    assign ex_op1 = fwd_e1 ? wd : ex_rs1;
    assign ex_op2 = fwd_e2 ? wd : ex_rs2;
    assign alu_a  = a_sel ? ex_pc : ex_op1;
    assign alu_b  = b_sel ? ex_imm : ex_op2;

    // Jumps use the ALU sum, branches add the offset to their own PC
    assign target = b_sel ? {alu_result[31:1], 1'b0} : ex_pc + ex_imm;

    // Execute to writeback
    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_alu <= alu_result;
            wb_pc4 <= ex_pc4;
            wb_rd  <= ex_rd;
        end
    end

    always_comb begin
        case (wb_sel)
            cpu_pkg::WB_LOAD: wd = load_data;
            cpu_pkg::WB_LINK: wd = wb_pc4;
            default:          wd = wb_alu;
        endcase
    end

    controller u_controller (
        .clk(clk), .rst(rst), .inst(inst),
        .br_eq(br_eq), .br_lt(br_lt), .stall(stall),
        .pc_sel(pc_sel), .inst_nop(inst_nop), .reg_we(reg_we),
        .a_sel(a_sel), .b_sel(b_sel), .br_unsigned(br_unsigned),
        .mem_we(mem_we), .imm_kind(imm_kind), .alu_op(alu_op),
        .mem_kind(mem_kind), .wb_sel(wb_sel),
        .fwd_d1(fwd_d1), .fwd_d2(fwd_d2), .fwd_e1(fwd_e1), .fwd_e2(fwd_e2)
    );

    reg_file u_reg_file (
        .clk(clk), .we(reg_we),
        .ra1(inst[19:15]), .ra2(inst[24:20]), .wa(wb_rd), .wd(wd),
        .rd1(rd1), .rd2(rd2)
    );

    imm_gen u_imm_gen (
        .inst(inst[31:7]), .kind(imm_kind), .imm(imm)
    );

    alu u_alu (
        .a(alu_a), .b(alu_b), .op(alu_op), .br_unsigned(br_unsigned),
        .result(alu_result), .br_eq(br_eq), .br_lt(br_lt)
    );

    mem_unit u_mem_unit (
        .clk(clk), .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .fetch_addr(next_pc), .inst(fetch_inst),
        .addr(alu_result), .wdata(ex_op2), .we(mem_we), .kind(mem_kind),
        .rdata(load_data), .out_write(out_write)
    );

    out_port u_out_port (
        .clk(clk), .rst(rst), .write(out_write), .wdata(ex_op2),
        .out_req(out_req), .out_data(out_data), .out_ack(out_ack), .stall(stall)
    );

endmodule

/* tb.f */
+incdir+source
source/cpu_pkg.sv
source/controller.sv
source/alu.sv
source/reg_file.sv
source/imm_gen.sv
source/mem_unit.sv
source/out_port.sv
source/riscv_core.sv
testbench/tb_riscv_core.sv

/* testbench/program_vectors.txt */
# prog <instruction word, hex>   loaded from word 0 upward
# expect <name> <value, hex>     expected output words in order
prog 80000537
prog 100005B7
prog 00500093
prog FFD08113
prog 002081B3
prog 00352023
prog 40110233
prog 401252B3
prog 00125333
prog 0062C3B3
prog 00752023
prog 00122433
prog 0040B4B3
prog 00441613
prog 00966633
prog 00C52023
prog 0045A023
prog 08500693
prog 00D580A3
prog 0005A703
prog 00E52023
prog 00158783
prog 0015C803
prog 00F52023
prog 01052023
prog 00000A13
prog 00108463
prog 001A0A13
prog 00208463
prog 002A0A13
prog 00209463
prog 004A0A13
prog 00109463
prog 008A0A13
prog 00124463
prog 010A0A13
prog 0040C463
prog 020A0A13
prog 0040D463
prog 040A0A13
prog 00125463
prog 080A0A13
prog 0040E463
prog 100A0A13
prog 00126463
prog 200A0A13
prog 00127463
prog 400A0A13
prog 0040F463
prog 800A0A13
prog 01452023
prog 00C00AEF
prog 00152023
prog 00152023
prog 01552023
prog 00000B17
prog 010B0BE7
prog 00152023
prog 00152023
prog 01752023
prog 0000006F
expect add_fwd 00000007
expect shift_xor F8000000
expect slt_sltu 00000011
expect lw_use FFFF85FD
expect lb_sign FFFFFF85
expect lbu_zero 00000085
expect branches FFFFFAAA
expect jal_link 000000D0
expect jalr_link 000000E4

/* testbench/tb_riscv_core.sv */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_riscv_core;

    logic                           clk;
    logic                           rst;
    logic                           prog_we;
    logic [$clog2(`IMEM_WORDS)-1:0] prog_addr;
    logic [31:0]                    prog_data;
    logic                           out_req;
    logic [`XLEN-1:0]               out_data;
    logic                           out_ack;

    logic [31:0]      prog_words [$];
    logic [31:0]      exp_values [$];
    logic [8*24-1:0]  exp_names  [$];

    int          errors;
    int          passes;
    int          cycles;
    int          limit;
    logic        extra_seen;
    logic [31:0] got;

    riscv_core UUT (
        .clk(clk), .rst(rst),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .out_req(out_req), .out_data(out_data), .out_ack(out_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog that starts counting once the core runs
    initial begin
        wait (limit > 0);
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: outputs still missing after %0d cycles", limit);
        $display("test failed");
        $finish;
    end

    task automatic load_vectors;
        int              fd;
        int              n;
        logic [8*96-1:0] line;
        logic [8*8-1:0]  tag;
        logic [8*24-1:0] name;
        logic [31:0]     word;
        fd = $fopen("testbench/program_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/program_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                if (n > 0) begin
                    tag = '0;
                    n = $sscanf(line, "%s", tag);
                    if (tag == "prog") begin
                        n = $sscanf(line, "%s %h", tag, word);
                        prog_words.push_back(word);
                    end else if (tag == "expect") begin
                        n = $sscanf(line, "%s %s %h", tag, name, word);
                        exp_names.push_back(name);
                        exp_values.push_back(word);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_value(input logic [8*24-1:0] name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %0s expected %08h actual %08h", name, expected, actual);
            errors++;
        end else begin
            $display("ok %0s %08h", name, actual);
            passes++;
        end
    endtask

    // Request must stay up with the same word until it is acknowledged
    task automatic verify_held(input logic [31:0] held);
        if (!out_req || out_data !== held) begin
            $display("out_data changed or out_req dropped before the acknowledge");
            errors++;
        end
    endtask

    // One full four-phase transfer with random ack timing
    task automatic take_output(output logic [31:0] value);
        int          delay;
        logic [31:0] held;
        while (!out_req)
            @(negedge clk);
        held  = out_data;
        delay = $urandom % 8;
        repeat (delay) begin
            @(negedge clk);
            verify_held(held);
        end
        out_ack = 1'b1;
        @(negedge clk);
        while (out_req) begin
            if (out_data !== held) begin
                $display("out_data changed while out_req was high");
                errors++;
            end
            @(negedge clk);
        end
        delay = $urandom % 4;
        repeat (delay) begin
            @(negedge clk);
            if (out_req) begin
                $display("out_req rose again before out_ack dropped");
                errors++;
            end
        end
        out_ack = 1'b0;
        value   = held;
    endtask

    initial begin
        rst        = 1'b1;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        out_ack    = 1'b0;
        errors     = 0;
        passes     = 0;
        cycles     = 0;
        limit      = 0;
        extra_seen = 1'b0;
        void'($urandom(32'hcfc87cba));

        load_vectors();

        if (prog_words.size() == 0 || exp_values.size() == 0) begin
            $display("no program or expected values were loaded");
            $display("test failed");
            $finish;
        end else begin
            // Program goes in while the core is held in reset
            for (int i = 0; i < prog_words.size(); i++) begin
                @(negedge clk);
                prog_we   = 1'b1;
                prog_addr = i[$clog2(`IMEM_WORDS)-1:0];
                prog_data = prog_words[i];
            end
            @(negedge clk);
            prog_we = 1'b0;
            repeat (5) begin
                @(negedge clk);
                if (out_req) begin
                    $display("out_req raised during reset");
                    errors++;
                end
            end
            limit = 200 + 20 * exp_values.size();
            rst   = 1'b0;

            for (int i = 0; i < exp_values.size(); i++) begin
                take_output(got);
                check_value(exp_names[i], exp_values[i], got);
            end

            // Program now spins, so nothing further may come out
            repeat (40) begin
                @(negedge clk);
                if (out_req && !extra_seen) begin
                    $display("unexpected extra output %08h", out_data);
                    errors++;
                    extra_seen = 1'b1;
                end
            end

            $display("%0d checks passed, %0d errors", passes, errors);
            if (errors == 0)
                $display("test passed");
            else
                $display("test failed");
            $finish;
        end
    end

endmodule
